/* compile.f */
src/cam_switch_pkg.sv
src/key_debounce.sv
src/cam_select_ctrl.sv
src/video_delay_line.sv
src/pixel_fifo.sv
src/minor_frame_aligner.sv
src/cam_switch.sv
sim/tb_cam_switch.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_cam_switch \
    -f compile.f

out=$(./obj_dir/Vtb_cam_switch)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* sim/tb_cam_switch.sv */
`timescale 1ns/10ps

module tb_cam_switch;

    localparam int H_VIS      = 32;
    localparam int H_TOT      = 40;   // active plus blanking.
    localparam int V_VIS      = 4;
    localparam int V_TOT      = 6;    // last line carries vsync.
    localparam int FRAME_CYC  = H_TOT * V_TOT;
    localparam int MINOR_LEAD = 45;   // main vsync commit lands inside minor line 0.
    localparam int FIFO_DEPTH = 2**cam_switch_pkg::FIFO_AW;

    logic                        main_clk;
    logic                        rstn;
    cam_switch_pkg::video_beat_t i_main_beat;
    cam_switch_pkg::video_beat_t i_minor_beat;
    logic                        i_key;
    cam_switch_pkg::video_beat_t o_beat;

    // reference model state.
    cam_switch_pkg::video_beat_t hist [$];   // last PIX_DELAY driven main beats.
    cam_switch_pkg::rgb_t        pix_q [$];
    cam_switch_pkg::cam_sel_e    m_sel;
    cam_switch_pkg::cam_sel_e    m_req;
    logic                        m_vs_d;
    logic                        m_press;
    logic [1:0]                  m_sync;
    logic                        m_level;
    int                          m_run;

    int   main_pos;
    logic key_lvl;
    logic out_de;
    logic out_is_main;
    int   err_cnt;
    int   tmo_cnt;

    cam_switch dut0 (
        .main_clk    (main_clk    ),
        .rstn        (rstn        ),
        .i_main_beat (i_main_beat ),
        .i_minor_beat(i_minor_beat),
        .i_key       (i_key       ),
        .o_beat      (o_beat      )
    );

    always #2 main_clk = ~main_clk;

    function automatic cam_switch_pkg::video_beat_t make_beat(input int pos,
                                                              input cam_switch_pkg::rgb_t pix);
        cam_switch_pkg::video_beat_t b;
        int                          h;
        int                          v;
        h       = pos % H_TOT;
        v       = pos / H_TOT;
        b       = '0;
        b.de    = (h < H_VIS) && (v < V_VIS);
        b.hsync = (h >= H_VIS + 2) && (h < H_VIS + 6);
        b.vsync = v == V_TOT - 1;
        b.pix   = b.de ? pix : '0;
        b.x     = cam_switch_pkg::X_W'(h);
        b.y     = cam_switch_pkg::Y_W'(v);
        return b;
    endfunction

    function automatic cam_switch_pkg::rgb_t rand_pix();
        logic [31:0] rnd;
        rnd = $urandom();
        return rnd[23:0];
    endfunction

    task automatic check_value(input string name, input logic [47:0] got,
                               input logic [47:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED time=%0t signal=%s got=%0h expected=%0h",
                     $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // timing fields follow main and pix follows the selected source.
    task automatic check_output();
        cam_switch_pkg::video_beat_t exp;
        exp = hist[0];
        if (m_sel == cam_switch_pkg::CAM_MINOR) begin
            exp.pix = (pix_q.size() == 0) ? cam_switch_pkg::FILL_PIX : pix_q[0];
        end
        check_value("o_beat.hsync", 48'(o_beat.hsync), 48'(exp.hsync));
        check_value("o_beat.vsync", 48'(o_beat.vsync), 48'(exp.vsync));
        check_value("o_beat.de", 48'(o_beat.de), 48'(exp.de));
        check_value("o_beat.x", 48'(o_beat.x), 48'(exp.x));
        check_value("o_beat.y", 48'(o_beat.y), 48'(exp.y));
        check_value("o_beat.pix", 48'(o_beat.pix), 48'(exp.pix));
        out_de      = o_beat.de;
        out_is_main = o_beat.pix == hist[0].pix;
    endtask

    // one clock edge of the reference model, on the inputs sampled at that edge.
    task automatic advance_model();
        cam_switch_pkg::video_beat_t cur_main;
        cam_switch_pkg::video_beat_t cur_minor;
        cam_switch_pkg::cam_sel_e    sel_old;
        logic                        full_old;
        cur_main  = i_main_beat;
        cur_minor = i_minor_beat;
        sel_old   = m_sel;

        if (m_vs_d && cur_main.vsync) begin
            m_sel = m_req;  // commit on the second vsync beat.
        end
        if (m_press) begin
            m_req = (m_req == cam_switch_pkg::CAM_MAIN) ?
                    cam_switch_pkg::CAM_MINOR : cam_switch_pkg::CAM_MAIN;
        end
        m_vs_d = cur_main.vsync;

        // a new level must hold for DEBOUNCE_CYCLES edges after the sync flops.
        m_press = 1'b0;
        if (m_sync[1] != m_level) begin
            m_run++;
            if (m_run == cam_switch_pkg::DEBOUNCE_CYCLES) begin
                m_level = m_sync[1];
                m_press = m_sync[1];
                m_run   = 0;
            end
        end else begin
            m_run = 0;
        end
        m_sync = {m_sync[0], i_key};

        full_old = pix_q.size() == FIFO_DEPTH;
        if (sel_old == cam_switch_pkg::CAM_MAIN || cur_minor.vsync) begin
            pix_q.delete();
        end else begin
            if (hist[0].de && pix_q.size() > 0) begin
                void'(pix_q.pop_front());
            end
            if (cur_minor.de && !full_old) begin
                pix_q.push_back(cur_minor.pix);
            end
        end
    endtask

    task automatic step_cycle();
        cam_switch_pkg::video_beat_t nxt;
        @(posedge main_clk);
        #1;
        check_output();
        advance_model();
        nxt          = make_beat(main_pos, rand_pix());
        i_main_beat  = nxt;
        i_minor_beat = make_beat((main_pos + MINOR_LEAD) % FRAME_CYC, rand_pix());
        i_key        = key_lvl;
        hist.push_back(nxt);
        void'(hist.pop_front());
        main_pos = (main_pos + 1) % FRAME_CYC;
    endtask

    task automatic run_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            step_cycle();
        end
    endtask

    task automatic wait_frame_pos(input int pos);
        int cnt;
        cnt = 0;
        while (main_pos != pos && cnt < FRAME_CYC + 1) begin
            step_cycle();
            cnt++;
        end
        if (main_pos != pos) begin
            $display("timed out waiting for main frame position %0d", pos);
            tmo_cnt++;
        end
    endtask

    task automatic wait_output_source(input logic want_main, input int limit);
        int   cnt;
        logic seen;
        cnt  = 0;
        seen = 1'b0;
        while (!seen && cnt < limit) begin
            step_cycle();
            cnt++;
            seen = out_de && (out_is_main == want_main);
        end
        if (!seen) begin
            $display("timed out waiting for %s camera pixels on the output",
                     want_main ? "main" : "minor");
            tmo_cnt++;
        end
    endtask

    task automatic press_key(input int high_cycles);
        key_lvl = 1'b1;
        run_cycles(high_cycles);
        key_lvl = 1'b0;
        run_cycles(cam_switch_pkg::DEBOUNCE_CYCLES + 8);  // released long enough to rearm.
    endtask

    initial begin
        cam_switch_pkg::video_beat_t idle_beat;
        void'($urandom(86050));
        main_clk     = 1'b0;
        rstn         = 1'b0;
        i_main_beat  = '0;
        i_minor_beat = '0;
        i_key        = 1'b0;
        idle_beat    = '0;
        key_lvl      = 1'b0;
        main_pos     = 0;
        err_cnt      = 0;
        tmo_cnt      = 0;
        out_de       = 1'b0;
        out_is_main  = 1'b1;
        m_sel        = cam_switch_pkg::CAM_MAIN;
        m_req        = cam_switch_pkg::CAM_MAIN;
        m_vs_d       = 1'b0;
        m_press      = 1'b0;
        m_sync       = '0;
        m_level      = 1'b0;
        m_run        = 0;
        pix_q.delete();
        hist.delete();
        for (int i = 0; i < cam_switch_pkg::PIX_DELAY; i++) begin
            hist.push_back(idle_beat);
        end

        repeat (8) @(posedge main_clk);
        #1;
        rstn = 1'b1;

        // with no key the output is the delayed main camera.
        run_cycles(2 * FRAME_CYC);

        // short glitch on the key.
        wait_frame_pos(40);
        press_key(8);
        run_cycles(2 * FRAME_CYC);

        // a real press mid frame shows minor only after the next vsync.
        wait_frame_pos(40);
        press_key(cam_switch_pkg::DEBOUNCE_CYCLES + 14);
        wait_output_source(1'b0, 2 * FRAME_CYC);
        run_cycles(2 * FRAME_CYC);

        // second press goes back to main.
        wait_frame_pos(40);
        press_key(cam_switch_pkg::DEBOUNCE_CYCLES + 14);
        wait_output_source(1'b1, 2 * FRAME_CYC);
        run_cycles(2 * FRAME_CYC);

        // back to minor again with a queue that starts empty.
        wait_frame_pos(40);
        press_key(cam_switch_pkg::DEBOUNCE_CYCLES + 14);
        wait_output_source(1'b0, 2 * FRAME_CYC);
        run_cycles(FRAME_CYC);

        $display("errors: %0d check failures, %0d timeouts", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_cam_switch

/* src/cam_select_ctrl.sv */
`timescale 1ns/10ps

module cam_select_ctrl (
    input  logic                     main_clk,
    input  logic                     rstn,
    input  logic                     i_key,
    input  logic                     i_main_vsync,
    input  logic                     i_minor_vsync,
    input  logic                     i_minor_de,
    output cam_switch_pkg::cam_sel_e o_cam_sel,
    output logic                     o_fifo_clr,
    output logic                     o_fifo_wr_en
);

    logic                     press;
    cam_switch_pkg::cam_sel_e cam_req;
    logic                     main_vsync_d;
    logic                     commit;

    key_debounce u_key_debounce (
        .main_clk(main_clk),
        .rstn    (rstn    ),
        .i_key   (i_key   ),
        .o_press (press   )
    );

    // commit on the second cycle of main vsync so a single stray vsync beat is ignored.
    assign commit = main_vsync_d && i_main_vsync;

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            cam_req      <= cam_switch_pkg::CAM_MAIN;
            main_vsync_d <= 1'b0;
            o_cam_sel    <= cam_switch_pkg::CAM_MAIN;
        end else begin
            main_vsync_d <= i_main_vsync;
            if (press) begin
                cam_req <= (cam_req == cam_switch_pkg::CAM_MAIN) ?
                           cam_switch_pkg::CAM_MINOR : cam_switch_pkg::CAM_MAIN;
            end
            if (commit) begin
                o_cam_sel <= cam_req;
            end
        end
    end

    // minor pixels are only queued while they can be shown.
    assign o_fifo_wr_en = i_minor_de && (o_cam_sel == cam_switch_pkg::CAM_MINOR);

    // empty the queue at every minor frame start and while main is on.
    assign o_fifo_clr = (o_cam_sel == cam_switch_pkg::CAM_MAIN) || i_minor_vsync;

endmodule : cam_select_ctrl

/* src/cam_switch.sv */
`timescale 1ns/10ps

module cam_switch (
    input  logic                        main_clk,
    input  logic                        rstn,
    input  cam_switch_pkg::video_beat_t i_main_beat,
    input  cam_switch_pkg::video_beat_t i_minor_beat,
    input  logic                        i_key,
    output cam_switch_pkg::video_beat_t o_beat
);

    cam_switch_pkg::cam_sel_e    cam_sel;
    logic                        fifo_clr;
    logic                        fifo_wr_en;
    logic                        fifo_rd_en;
    logic                        fifo_empty;
    cam_switch_pkg::rgb_t        fifo_pix;
    cam_switch_pkg::video_beat_t main_dly;  // main beat PIX_DELAY-1 cycles late.

    cam_select_ctrl u_cam_select_ctrl (
        .main_clk     (main_clk          ),
        .rstn         (rstn              ),
        .i_key        (i_key             ),
        .i_main_vsync (i_main_beat.vsync ),
        .i_minor_vsync(i_minor_beat.vsync),
        .i_minor_de   (i_minor_beat.de   ),
        .o_cam_sel    (cam_sel           ),
        .o_fifo_clr   (fifo_clr          ),
        .o_fifo_wr_en (fifo_wr_en        )
    );

    video_delay_line u_main_delay (
        .main_clk(main_clk   ),
        .rstn    (rstn       ),
        .i_beat  (i_main_beat),
        .o_beat  (main_dly   )
    );

    pixel_fifo u_minor_fifo (
        .main_clk(main_clk        ),
        .rstn    (rstn            ),
        .i_clr   (fifo_clr        ),
        .i_wr_en (fifo_wr_en      ),
        .i_wr_pix(i_minor_beat.pix),
        .i_rd_en (fifo_rd_en      ),
        .o_rd_pix(fifo_pix        ),
        .o_empty (fifo_empty      )
    );

    minor_frame_aligner u_aligner (
        .main_clk    (main_clk  ),
        .rstn        (rstn      ),
        .i_beat      (main_dly  ),
        .i_cam_sel   (cam_sel   ),
        .i_fifo_pix  (fifo_pix  ),
        .i_fifo_empty(fifo_empty),
        .o_fifo_rd_en(fifo_rd_en),
        .o_beat      (o_beat    )
    );

endmodule : cam_switch

/* src/cam_switch_pkg.sv */
package cam_switch_pkg;

    // active picture size.
    localparam int H_ACT = 1280;
    localparam int V_ACT = 720;

    // coordinate widths.
    localparam int X_W = $clog2(H_ACT);
    localparam int Y_W = $clog2(V_ACT);

    // input beat to output beat, in main_clk cycles.
    localparam int PIX_DELAY  = 5;
    localparam int DLY_STAGES = PIX_DELAY - 1;  // last stage sits in the aligner.

    // key must hold a new level this long.
    localparam int DEBOUNCE_CYCLES = 16;
    localparam int DEB_CNT_W       = $clog2(DEBOUNCE_CYCLES);

    // 2048 pixels hold more than one active line.
    localparam int FIFO_AW = 11;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // one video beat as carried by both cameras.
    typedef struct packed {
        logic           hsync;
        logic           vsync;
        logic           de;
        rgb_t           pix;
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
    } video_beat_t;

    typedef enum logic {
        CAM_MINOR = 1'b0,
        CAM_MAIN  = 1'b1
    } cam_sel_e;

    // white is shown when no minor pixel is queued.
    localparam rgb_t FILL_PIX = '{r: 8'hff, g: 8'hff, b: 8'hff};

endpackage : cam_switch_pkg

/* src/key_debounce.sv */
`timescale 1ns/10ps

module key_debounce (
    input  logic main_clk,
    input  logic rstn,
    input  logic i_key,
    output logic o_press
);

    logic [1:0]                             key_sync;
    logic                                   key_level;  // accepted key level.
    logic [cam_switch_pkg::DEB_CNT_W-1:0]   stable_cnt;
    logic                                   key_differs;
    logic                                   cnt_done;

    assign key_differs = key_sync[1] != key_level;
    assign cnt_done    = stable_cnt == cam_switch_pkg::DEB_CNT_W'(
                             cam_switch_pkg::DEBOUNCE_CYCLES - 1);

    // raw key is asynchronous to main_clk.
    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            key_sync <= '0;
        end else begin
            key_sync <= {key_sync[0], i_key};
        end
    end

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            stable_cnt <= '0;
            key_level  <= 1'b0;
            o_press    <= 1'b0;
        end else begin
            o_press <= 1'b0;
            if (key_differs) begin
                if (cnt_done) begin
                    stable_cnt <= '0;
                    key_level  <= key_sync[1];
                    o_press    <= key_sync[1];  // only the rising level counts.
                end else begin
                    stable_cnt <= stable_cnt + 1'b1;
                end
            end else begin
                // a bounce back restarts the count.
                stable_cnt <= '0;
            end
        end
    end

endmodule : key_debounce

/* src/minor_frame_aligner.sv */
`timescale 1ns/10ps

module minor_frame_aligner (
    input  logic                        main_clk,
    input  logic                        rstn,
    input  cam_switch_pkg::video_beat_t i_beat,
    input  cam_switch_pkg::cam_sel_e    i_cam_sel,
    input  cam_switch_pkg::rgb_t        i_fifo_pix,
    input  logic                        i_fifo_empty,
    output logic                        o_fifo_rd_en,
    output cam_switch_pkg::video_beat_t o_beat
);

    logic                        minor_on;
    cam_switch_pkg::video_beat_t merged;

    assign minor_on = i_cam_sel == cam_switch_pkg::CAM_MINOR;

    // one minor pixel per delayed main active beat.
    assign o_fifo_rd_en = i_beat.de && minor_on && !i_fifo_empty;

    // timing fields always come from main.
    always_comb begin
        merged = i_beat;
        if (minor_on) begin
            merged.pix = i_fifo_empty ? cam_switch_pkg::FILL_PIX : i_fifo_pix;
        end
    end

    // final pipeline stage.
    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            o_beat <= '0;
        end else begin
            o_beat <= merged;
        end
    end

endmodule : minor_frame_aligner

/* src/pixel_fifo.sv */
`timescale 1ns/10ps

module pixel_fifo (
    input  logic                 main_clk,
    input  logic                 rstn,
    input  logic                 i_clr,
    input  logic                 i_wr_en,
    input  cam_switch_pkg::rgb_t i_wr_pix,
    input  logic                 i_rd_en,
    output cam_switch_pkg::rgb_t o_rd_pix,
    output logic                 o_empty
);

    cam_switch_pkg::rgb_t mem [2**cam_switch_pkg::FIFO_AW];

    // one extra bit tells full from empty.
    logic [cam_switch_pkg::FIFO_AW:0] wr_ptr;
    logic [cam_switch_pkg::FIFO_AW:0] rd_ptr;
    logic                             full;
    logic                             do_wr;
    logic                             do_rd;

    assign o_empty = wr_ptr == rd_ptr;
    assign full    = (wr_ptr[cam_switch_pkg::FIFO_AW] != rd_ptr[cam_switch_pkg::FIFO_AW]) &&
                     (wr_ptr[cam_switch_pkg::FIFO_AW-1:0] == rd_ptr[cam_switch_pkg::FIFO_AW-1:0]);

    assign do_wr = i_wr_en && !full;   // overflow pixels are lost.
    assign do_rd = i_rd_en && !o_empty;

    always_ff @(posedge main_clk) begin
        if (do_wr) begin
            mem[wr_ptr[cam_switch_pkg::FIFO_AW-1:0]] <= i_wr_pix;
        end
    end

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (i_clr) begin
            // clear wins over a push or pop in the same cycle.
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // the head falls through with no read latency.
    assign o_rd_pix = mem[rd_ptr[cam_switch_pkg::FIFO_AW-1:0]];

endmodule : pixel_fifo

/* src/video_delay_line.sv */
`timescale 1ns/10ps

module video_delay_line (
    input  logic                        main_clk,
    input  logic                        rstn,
    input  cam_switch_pkg::video_beat_t i_beat,
    output cam_switch_pkg::video_beat_t o_beat
);

    cam_switch_pkg::video_beat_t dly_q [cam_switch_pkg::DLY_STAGES];

    // one stage per clock toward the aligner.
    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < cam_switch_pkg::DLY_STAGES; i++) begin
                dly_q[i] <= '0;
            end
        end else begin
            dly_q[0] <= i_beat;
            for (int i = 1; i < cam_switch_pkg::DLY_STAGES; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    assign o_beat = dly_q[cam_switch_pkg::DLY_STAGES-1];

endmodule : video_delay_line
